//--- files.f
common/ic_pkg.sv
icache/ic_refill_counter.sv
icache/ic_miss_fsm.sv
icache/ic_tag_array.sv
icache/ic_data_array.sv
icache/ic_top.sv
verif/ic_tb_clock.sv
verif/ic_checker.sv
verif/ic_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - common/ic_pkg.sv
  - icache/ic_refill_counter.sv
  - icache/ic_miss_fsm.sv
  - icache/ic_tag_array.sv
  - icache/ic_data_array.sv
  - icache/ic_top.sv
  - target: test
    files:
      - verif/ic_tb_clock.sv
      - verif/ic_checker.sv
      - verif/ic_tb.sv

//--- verif/ic_tb.sv
// ----------------------------------------------------------
// Directed testbench for the instruction cache
// Memory word at address A is A ^ 32'h5a5a_0000
// Memory acks each beat after 0 to 3 random wait cycles
// Responses are sampled on the falling edge
// ----------------------------------------------------------

module ic_tb;
  import ic_pkg::*;

  localparam int WD_CYCLES_PER_FETCH = 40;
  localparam int WD_MARGIN           = 100;

  logic     clk;
  logic     reset_n;
  ic_req_t  req         = '0;
  logic     flush_valid = 1'b0;
  logic     fence_i     = 1'b0;
  wb_s2m_t  wb_in       = '0;
  logic     ready;
  ic_resp_t resp;
  wb_m2s_t  wb_out;

  logic [31:0] lfsr_state = 32'hf5de_46cf;
  vaddr_t      beat_log[$];     // Addresses of acked beats
  vaddr_t      burst_addr[$];
  logic        burst_miss[$];
  logic        mem_busy;
  logic [1:0]  mem_wait;
  int          value_errs = 0;
  int          other_errs = 0;
  int          fetch_cnt  = 0;
  int          cycle_cnt  = 0;

  ic_tb_clock u_clock (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  ic_top dut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_req         (req),
    .o_ready       (ready),
    .i_flush_valid (flush_valid),
    .i_fence_i     (fence_i),
    .o_resp        (resp),
    .o_wb          (wb_out),
    .i_wb          (wb_in)
  );

  bind ic_top ic_checker u_checker (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_wb_m2s      (o_wb),
    .i_wb_s2m      (i_wb),
    .i_resp        (o_resp),
    .i_flush_valid (i_flush_valid)
  );

  // ----------------------------------------------------------
  // Random source and reference model
  // ----------------------------------------------------------
  function automatic logic lfsr_next_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;   // Taps 32, 22, 2, 1
    end
    return out;
  endfunction

  function automatic logic [1:0] draw_wait();
    logic [1:0] w;
    w[0] = lfsr_next_bit();
    w[1] = lfsr_next_bit();
    return w;
  endfunction

  function automatic logic [31:0] mem_word(input vaddr_t a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic ic_line_t exp_line(input vaddr_t a);
    vaddr_t base;
    base = {a[31:3], 3'b000};
    return {mem_word(base + 32'd4), mem_word(base)};   // Beat 0 in the low half
  endfunction

  function automatic ic_resp_t expect_resp(input vaddr_t a, input logic miss);
    ic_resp_t r;
    r.valid = 1'b1;
    r.miss  = miss;
    r.vaddr = a;
    r.data  = miss ? '0 : exp_line(a);
    return r;
  endfunction

  // Wishbone slave, one beat at a time
  always @(posedge clk or negedge reset_n) begin : mem_model
    logic [1:0] draw;
    if (!reset_n) begin
      wb_in    <= '0;
      mem_busy <= 1'b0;
      mem_wait <= '0;
    end else if (wb_in.ack) begin
      wb_in.ack <= 1'b0;
      mem_busy  <= 1'b0;
    end else if (wb_out.cyc && wb_out.stb) begin
      draw = mem_busy ? mem_wait : draw_wait();
      if (draw == 2'd0) begin
        if (wb_out.we !== 1'b0) begin
          other_errs++;
          $display("Wishbone we not low on a refill beat at %0t", $time);
        end
        wb_in.ack <= 1'b1;
        wb_in.dat <= mem_word(wb_out.adr);
        beat_log.push_back(wb_out.adr);
      end else begin
        mem_busy <= 1'b1;
        mem_wait <= draw - 2'd1;
      end
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_resp(input string name, input ic_resp_t got, input ic_resp_t exp);
    if (got.valid !== exp.valid) begin
      value_errs++;
      $display("** Error at %0t: %s.valid is %0b, expected %0b",
               $time, name, got.valid, exp.valid);
    end else if (exp.valid) begin
      if (got.miss !== exp.miss) begin
        value_errs++;
        $display("** Error at %0t: %s.miss is %0b, expected %0b",
                 $time, name, got.miss, exp.miss);
      end
      if (got.vaddr !== exp.vaddr) begin
        value_errs++;
        $display("** Error at %0t: %s.vaddr is %h, expected %h",
                 $time, name, got.vaddr, exp.vaddr);
      end
      if (!exp.miss && got.data !== exp.data) begin
        value_errs++;
        $display("** Error at %0t: %s.data is %h, expected %h",
                 $time, name, got.data, exp.data);
      end
    end
  endtask

  task automatic check_adr(input string name, input vaddr_t got, input vaddr_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------
  task automatic wait_ready();
    @(negedge clk);
    while (!ready) @(negedge clk);
  endtask

  // One request per cycle, response k checked two cycles after it
  task automatic run_burst();
    ic_resp_t none;
    int       n;
    none = '0;
    n    = burst_addr.size();
    wait_ready();
    for (int k = 0; k < n + 2; k++) begin
      @(posedge clk);
      if (k < n) begin
        req <= '{valid: 1'b1, vaddr: burst_addr[k]};
        fetch_cnt++;
      end else begin
        req <= '0;
      end
      @(negedge clk);
      if (k >= 2) begin
        check_resp("o_resp", resp, expect_resp(burst_addr[k-2], burst_miss[k-2]));
      end else begin
        check_resp("o_resp", resp, none);
      end
    end
    burst_addr.delete();
    burst_miss.delete();
  endtask

  task automatic fetch_one(input vaddr_t a, input logic miss);
    burst_addr.push_back(a);
    burst_miss.push_back(miss);
    run_burst();
  endtask

  task automatic fill_line(input vaddr_t a);
    fetch_one(a, 1'b1);
    wait_ready();
  endtask

  // Fetch, then flush delay cycles after the request was driven
  task automatic flush_fetch(input vaddr_t a, input int delay);
    ic_resp_t none;
    none = '0;
    wait_ready();
    for (int k = 0; k < 5; k++) begin
      @(posedge clk);
      if (k == 0) begin
        req <= '{valid: 1'b1, vaddr: a};
        fetch_cnt++;
      end else begin
        req <= '0;
      end
      flush_valid <= (k == delay);
      @(negedge clk);
      if (k >= 1) begin
        check_resp("o_resp", resp, none);
      end
    end
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    @(negedge clk);
    if (ready !== 1'b1 || resp.valid !== 1'b0 || wb_out.cyc !== 1'b0
        || wb_out.stb !== 1'b0) begin
      other_errs++;
      $display("Outputs not in their idle state after reset at %0t", $time);
    end
  endtask

  task automatic test_cold_miss();
    vaddr_t base;
    base = 32'h0000_1008;
    beat_log.delete();
    fill_line(32'h0000_100c);
    if (beat_log.size() != 2) begin
      other_errs++;
      $display("Refill of line %h made %0d Wishbone beats instead of 2",
               base, beat_log.size());
    end else begin
      check_adr("o_wb.adr", beat_log[0], base);
      check_adr("o_wb.adr", beat_log[1], base + 32'd4);
    end
    fetch_one(32'h0000_100c, 1'b0);
  endtask

  task automatic test_streaming_hits();
    fill_line(32'h0000_2010);
    fill_line(32'h0000_3018);
    burst_addr = '{32'h0000_100c, 32'h0000_2010, 32'h0000_3018,
                   32'h0000_1008, 32'h0000_2014};
    burst_miss = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    run_burst();
  endtask

  // Set 5 only, so earlier lines stay put
  task automatic test_replacement();
    fill_line(32'h0001_0028);
    fill_line(32'h0002_0028);
    fill_line(32'h0003_0028);
    fetch_one(32'h0002_0028, 1'b0);
    fetch_one(32'h0001_0028, 1'b1);
    wait_ready();
  endtask

  // Lines of both ways were cached before the fence
  task automatic test_fence();
    wait_ready();
    @(posedge clk);
    fence_i <= 1'b1;
    @(posedge clk);
    fence_i <= 1'b0;
    fill_line(32'h0000_100c);
    fill_line(32'h0000_2010);
    fill_line(32'h0000_3018);
    fill_line(32'h0003_0028);
    fill_line(32'h0001_0028);
    fetch_one(32'h0000_100c, 1'b0);   // Refill after fence is kept
  endtask

  task automatic test_flush();
    flush_fetch(32'h0000_100c, 1);
    flush_fetch(32'h0000_100c, 2);
    fetch_one(32'h0000_100c, 1'b0);
  endtask

  // ----------------------------------------------------------
  // Run control
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic print_counts();
    $display("Errors: %0d value, %0d other, %0d assertion",
             value_errs, other_errs, dut.u_checker.fail_count);
  endtask

  initial begin : watchdog
    wait (cycle_cnt > WD_CYCLES_PER_FETCH * fetch_cnt + WD_MARGIN);
    $display("Timeout after %0d cycles with %0d fetches issued", cycle_cnt, fetch_cnt);
    print_counts();
    $display("test failed");
    $finish;
  end

  initial begin : main
    wait (reset_n === 1'b1);
    test_reset_state();
    test_cold_miss();
    test_streaming_hits();
    test_replacement();
    test_fence();
    test_flush();
    print_counts();
    if (value_errs + other_errs + dut.u_checker.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verif/ic_checker.sv
// ----------------------------------------------------------
// Bound assertions on the Wishbone port and the response
// fail_count is read by the testbench at the end of the run
// ----------------------------------------------------------

module ic_checker (
  input logic             i_clk,
  input logic             i_reset_n,
  input ic_pkg::wb_m2s_t  i_wb_m2s,
  input ic_pkg::wb_s2m_t  i_wb_s2m,
  input ic_pkg::ic_resp_t i_resp,
  input logic             i_flush_valid
);
  import ic_pkg::*;

  int fail_count = 0;

  // Bus cycle ends only after an acked beat
  a_cyc_end_on_ack: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $fell(i_wb_m2s.cyc) |-> $past(i_wb_s2m.ack && i_wb_m2s.stb))
    else begin
      fail_count++;
      $error("Wishbone cyc dropped without a final ack");
    end

  a_adr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_wb_m2s.stb && !i_wb_s2m.ack) |=> $stable(i_wb_m2s.adr))
    else begin
      fail_count++;
      $error("Wishbone adr changed while waiting for ack");
    end

  // Flush empties f1 and f2, so nothing leaves for three cycles
  a_flush_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush_valid |-> !i_resp.valid ##1 !i_resp.valid ##1 !i_resp.valid)
    else begin
      fail_count++;
      $error("Response valid during or right after flush");
    end

endmodule

//--- verif/ic_tb_clock.sv
// ----------------------------------------------------------
// Clock and reset for the cache testbench
// Period 4, reset low for the first 2 rising edges
// ----------------------------------------------------------

module ic_tb_clock (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
    forever #2 o_clk = ~o_clk;   // Half period
  end

  initial begin
    repeat (2) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

//--- icache/ic_top.sv
// ----------------------------------------------------------
// Instruction cache top, two ways, 16 sets, 64-bit lines
// f0 accepts, f1 reads tags and data, f2 responds
// A response comes two cycles after acceptance, no stall
// A miss response must be fetched again after the refill
// o_ready is low for the whole refill
// ----------------------------------------------------------

module ic_top (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  ic_pkg::ic_req_t  i_req,
  output logic             o_ready,
  input  logic             i_flush_valid,
  input  logic             i_fence_i,
  output ic_pkg::ic_resp_t o_resp,
  output ic_pkg::wb_m2s_t  o_wb,
  input  ic_pkg::wb_s2m_t  i_wb
);
  import ic_pkg::*;

  logic     w_f0_fire;
  ic_addr_u w_rd_addr;
  logic     r_f1_valid;
  ic_addr_u r_f1_addr;
  ic_ways_t w_f1_hit;
  logic     w_f1_miss;
  logic     r_f2_valid;
  logic     r_f2_miss;
  ic_addr_u r_f2_addr;
  ic_line_t w_f2_line;
  logic     w_fsm_idle;
  ic_ways_t w_victim;
  logic     w_wr;
  ic_ways_t w_wr_way;
  ic_addr_u w_wr_addr;
  ic_line_t w_wr_line;

  assign o_ready   = w_fsm_idle;
  assign w_f0_fire = i_req.valid & o_ready;

  // Arrays follow the refill line whenever no fetch is accepted
  assign w_rd_addr = w_f0_fire ? ic_addr_u'(i_req.vaddr) : w_wr_addr;

  assign w_f1_miss = r_f1_valid & ~(|w_f1_hit);

  // ----------------------------------------------------------
  // Pipeline registers
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_f1_valid <= 1'b0;
      r_f2_valid <= 1'b0;
      r_f2_miss  <= 1'b0;
    end else begin
      r_f1_valid <= w_f0_fire & ~i_flush_valid;
      r_f2_valid <= r_f1_valid & ~i_flush_valid;
      r_f2_miss  <= ~w_fsm_idle | ~(|w_f1_hit);   // Busy FSM counts as miss
    end
  end

  always_ff @(posedge i_clk) begin
    r_f1_addr <= w_rd_addr;
    r_f2_addr <= r_f1_addr;
  end

  assign o_resp.valid = r_f2_valid & ~i_flush_valid;
  assign o_resp.miss  = r_f2_miss;
  assign o_resp.vaddr = r_f2_addr.raw;
  assign o_resp.data  = w_f2_line;

  ic_tag_array u_tag_array (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_addr (w_rd_addr),
    .i_clear   (i_fence_i),
    .i_wr      (w_wr),
    .i_wr_addr (w_wr_addr),
    .o_f1_hit  (w_f1_hit),
    .o_victim  (w_victim)
  );

  ic_data_array u_data_array (
    .i_clk      (i_clk),
    .i_rd_index (w_rd_addr.fld.index),
    .i_wr       (w_wr),
    .i_wr_way   (w_wr_way),
    .i_wr_index (w_wr_addr.fld.index),
    .i_wr_line  (w_wr_line),
    .i_f1_hit   (w_f1_hit),
    .o_f2_line  (w_f2_line)
  );

  ic_miss_fsm u_miss_fsm (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_f1_miss     (w_f1_miss),
    .i_f1_addr     (r_f1_addr.raw),
    .i_flush_valid (i_flush_valid),
    .i_fence_i     (i_fence_i),
    .i_victim      (w_victim),
    .o_idle        (w_fsm_idle),
    .o_wb          (o_wb),
    .i_wb          (i_wb),
    .o_wr          (w_wr),
    .o_wr_way      (w_wr_way),
    .o_wr_addr     (w_wr_addr),
    .o_wr_line     (w_wr_line)
  );

endmodule

//--- icache/ic_data_array.sv
// ----------------------------------------------------------
// Line store for both ways
// Read at f0, way picked by the f1 hit, line out in f2
// No hit gives an all-zero line
// ----------------------------------------------------------

module ic_data_array (
  input  logic                            i_clk,
  input  logic [ic_pkg::IC_INDEX_W-1:0]   i_rd_index,
  input  logic                            i_wr,
  input  ic_pkg::ic_ways_t                i_wr_way,
  input  logic [ic_pkg::IC_INDEX_W-1:0]   i_wr_index,
  input  ic_pkg::ic_line_t                i_wr_line,
  input  ic_pkg::ic_ways_t                i_f1_hit,
  output ic_pkg::ic_line_t                o_f2_line
);
  import ic_pkg::*;

  ic_line_t r_mem     [IC_WAYS][IC_SETS];
  ic_line_t r_f1_line [IC_WAYS];
  ic_line_t w_f1_sel;

  always_ff @(posedge i_clk) begin
    for (int w = 0; w < IC_WAYS; w++) begin
      if (i_wr && i_wr_way[w]) begin
        r_mem[w][i_wr_index] <= i_wr_line;
      end
      r_f1_line[w] <= r_mem[w][i_rd_index];
    end
    o_f2_line <= w_f1_sel;
  end

  // One-hot AND-OR select
  always_comb begin
    w_f1_sel = '0;
    for (int w = 0; w < IC_WAYS; w++) begin
      w_f1_sel |= r_f1_line[w] & {IC_LINE_W{i_f1_hit[w]}};
    end
  end

endmodule

//--- icache/ic_tag_array.sv
// ----------------------------------------------------------
// Tag store with one valid bit per way and set
// Read at f0, hit vector valid in f1
// Victim bit per set toggles on every refill write there
// i_clear drops all valid bits and wins over a write
// ----------------------------------------------------------

module ic_tag_array (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  ic_pkg::ic_addr_u i_rd_addr,
  input  logic             i_clear,
  input  logic             i_wr,
  input  ic_pkg::ic_addr_u i_wr_addr,
  output ic_pkg::ic_ways_t o_f1_hit,
  output ic_pkg::ic_ways_t o_victim
);
  import ic_pkg::*;

  logic [IC_SETS-1:0]  r_valid [IC_WAYS];
  logic [IC_TAG_W-1:0] r_tag   [IC_WAYS][IC_SETS];
  logic [IC_SETS-1:0]  r_victim;

  logic                r_f1_valid [IC_WAYS];
  logic [IC_TAG_W-1:0] r_f1_tag   [IC_WAYS];
  ic_addr_u            r_f1_addr;
  logic                w_wr_sel;   // Way index of the refill

  assign w_wr_sel = r_victim[i_wr_addr.fld.index];
  assign o_victim = ic_ways_t'(1) << r_victim[r_f1_addr.fld.index];

  // ----------------------------------------------------------
  // Valid and victim bits
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int w = 0; w < IC_WAYS; w++) begin
        r_valid[w] <= '0;
      end
      r_victim <= '0;
    end else if (i_clear) begin
      for (int w = 0; w < IC_WAYS; w++) begin
        r_valid[w] <= '0;
      end
    end else if (i_wr) begin
      r_valid[w_wr_sel][i_wr_addr.fld.index] <= 1'b1;
      r_victim[i_wr_addr.fld.index]          <= ~w_wr_sel;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr && !i_clear) begin
      r_tag[w_wr_sel][i_wr_addr.fld.index] <= i_wr_addr.fld.tag;
    end
  end

  // f0 read into f1
  always_ff @(posedge i_clk) begin
    for (int w = 0; w < IC_WAYS; w++) begin
      r_f1_valid[w] <= r_valid[w][i_rd_addr.fld.index];
      r_f1_tag[w]   <= r_tag[w][i_rd_addr.fld.index];
    end
    r_f1_addr <= i_rd_addr;
  end

  always_comb begin
    for (int w = 0; w < IC_WAYS; w++) begin
      o_f1_hit[w] = r_f1_valid[w] & (r_f1_tag[w] == r_f1_addr.fld.tag);
    end
  end

endmodule

//--- icache/ic_miss_fsm.sv
// ----------------------------------------------------------
// Miss handler, one refill at a time over Wishbone classic
// Starts only from idle on an f1 miss without flush or fence
// A fence during the refill lets the bus cycle finish and
// drops the line instead of writing it
// ----------------------------------------------------------

module ic_miss_fsm (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_f1_miss,
  input  ic_pkg::vaddr_t   i_f1_addr,
  input  logic             i_flush_valid,
  input  logic             i_fence_i,
  input  ic_pkg::ic_ways_t i_victim,
  output logic             o_idle,
  output ic_pkg::wb_m2s_t  o_wb,
  input  ic_pkg::wb_s2m_t  i_wb,
  output logic             o_wr,
  output ic_pkg::ic_ways_t o_wr_way,
  output ic_pkg::ic_addr_u o_wr_addr,
  output ic_pkg::ic_line_t o_wr_line
);
  import ic_pkg::*;

  ic_state_e r_state;
  logic      w_start;
  logic      w_ack;
  logic      w_done;
  vaddr_t    w_base;
  vaddr_t    w_adr;
  ic_addr_u  r_miss_addr;
  ic_ways_t  r_victim;

  assign o_idle  = (r_state == IC_IDLE);
  assign w_start = o_idle & i_f1_miss & ~i_flush_valid & ~i_fence_i;
  assign w_base  = {i_f1_addr[VADDR_W-1:IC_OFFSET_W], {IC_OFFSET_W{1'b0}}};
  assign w_ack   = i_wb.ack & o_wb.stb;   // Ignore stray acks

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IC_IDLE;
    end else begin
      case (r_state)
        IC_IDLE: if (w_start) r_state <= IC_REFILL;
        IC_REFILL: begin
          if (w_done) r_state <= IC_IDLE;
          else if (i_fence_i) r_state <= IC_DISCARD;
        end
        IC_DISCARD: if (w_done) r_state <= IC_IDLE;
        default: r_state <= IC_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      r_miss_addr <= ic_addr_u'(i_f1_addr);
      r_victim    <= i_victim;
    end
  end

  // Wishbone master, held until each ack
  assign o_wb.cyc = ~o_idle;
  assign o_wb.stb = ~o_idle;
  assign o_wb.we  = 1'b0;
  assign o_wb.adr = w_adr;

  // Line write on the last ack, a fence in that cycle also drops it
  assign o_wr      = w_done & (r_state == IC_REFILL) & ~i_fence_i;
  assign o_wr_way  = r_victim;
  assign o_wr_addr = r_miss_addr;

  ic_refill_counter u_refill_counter (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_start   (w_start),
    .i_base    (w_base),
    .i_ack     (w_ack),
    .i_dat     (i_wb.dat),
    .o_adr     (w_adr),
    .o_done    (w_done),
    .o_line    (o_wr_line)
  );

endmodule

//--- icache/ic_refill_counter.sv
// ----------------------------------------------------------
// Beat counter for one line refill
// Beat n reads base + 4*n, beat 0 lands in the low word
// o_done and o_line are valid in the cycle of the last ack
// ----------------------------------------------------------

module ic_refill_counter (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_start,
  input  ic_pkg::vaddr_t                 i_base,
  input  logic                           i_ack,
  input  logic [ic_pkg::WB_DATA_W-1:0]   i_dat,
  output ic_pkg::vaddr_t                 o_adr,
  output logic                           o_done,
  output ic_pkg::ic_line_t               o_line
);
  import ic_pkg::*;

  localparam int BEAT_W = $clog2(IC_BEATS);

  logic [BEAT_W-1:0] r_beat;
  vaddr_t            r_base;
  ic_line_t          r_line;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_beat <= '0;
    end else if (i_start) begin
      r_beat <= '0;
    end else if (i_ack) begin
      r_beat <= r_beat + 1'b1;   // Wraps to 0 after the last beat
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      r_base <= i_base;
    end
    if (i_ack) begin
      r_line <= o_line;
    end
  end

  // Words enter at the top and shift down
  assign o_line = {i_dat, r_line[IC_LINE_W-1:WB_DATA_W]};
  assign o_adr  = r_base + (vaddr_t'(r_beat) << $clog2(WB_DATA_W / 8));
  assign o_done = i_ack & (r_beat == BEAT_W'(IC_BEATS - 1));

endmodule

//--- common/ic_pkg.sv
// ----------------------------------------------------------
// Shared types and sizes of the instruction cache
// Virtual addresses are used as physical addresses
// A line is two 32-bit Wishbone beats, beat 0 is the low half
// Sizes are fixed here and are not meant to be overridden
// ----------------------------------------------------------

package ic_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int VADDR_W     = 32;
  localparam int IC_WAYS     = 2;
  localparam int IC_SETS     = 16;
  localparam int IC_INDEX_W  = 4;
  localparam int IC_LINE_W   = 64;
  localparam int IC_OFFSET_W = 3;   // Byte offset within a line
  localparam int IC_TAG_W    = VADDR_W - IC_INDEX_W - IC_OFFSET_W;
  localparam int WB_DATA_W   = 32;
  localparam int IC_BEATS    = IC_LINE_W / WB_DATA_W;

  typedef logic [VADDR_W-1:0]   vaddr_t;
  typedef logic [IC_LINE_W-1:0] ic_line_t;
  typedef logic [IC_WAYS-1:0]   ic_ways_t;   // One-hot

  // ----------------------------------------------------------
  // Address views
  // ----------------------------------------------------------
  typedef struct packed {
    logic [IC_TAG_W-1:0]    tag;
    logic [IC_INDEX_W-1:0]  index;
    logic [IC_OFFSET_W-1:0] offset;
  } ic_addr_fields_t;

  typedef union packed {
    vaddr_t          raw;
    ic_addr_fields_t fld;
  } ic_addr_u;

  // ----------------------------------------------------------
  // Fetch side
  // ----------------------------------------------------------
  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } ic_req_t;

  typedef struct packed {
    logic     valid;
    logic     miss;    // Fetch unit must request again
    vaddr_t   vaddr;
    ic_line_t data;
  } ic_resp_t;

  // ----------------------------------------------------------
  // Wishbone classic
  // ----------------------------------------------------------
  typedef struct packed {
    logic   cyc;
    logic   stb;
    logic   we;
    vaddr_t adr;
  } wb_m2s_t;

  typedef struct packed {
    logic                 ack;
    logic [WB_DATA_W-1:0] dat;
  } wb_s2m_t;

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REFILL,
    IC_DISCARD   // Refill outlived by a fence, line is dropped
  } ic_state_e;

endpackage
